/* Bender.yml */
package:
  name: soc_bus

sources:
  - hw/soc_bus_pkg.sv
  - hw/soc_mmap_pkg.sv
  - hw/nmi_if.sv
  - hw/bus_arbiter.sv
  - hw/nmi_regslice.sv
  - hw/bus_decoder.sv
  - hw/soc_bus.sv
  - target: simulation
    files:
      - sim/soc_bus_properties.sv
      - sim/tb_soc_bus.sv

/* flist.f */
hw/soc_bus_pkg.sv
hw/soc_mmap_pkg.sv
hw/nmi_if.sv
hw/bus_arbiter.sv
hw/nmi_regslice.sv
hw/bus_decoder.sv
hw/soc_bus.sv
sim/soc_bus_properties.sv
sim/tb_soc_bus.sv

/* hw/bus_arbiter.sv */
/*
 * Two master arbiter for the native bus.
 * The first granted master keeps the bus until its transfer
 * completes; with both requesting while free, DMA wins.
 * Only the owner sees ready and read data.
 */
`timescale 1ns/10ps
`default_nettype none

module bus_arbiter (
  input  logic  clk_i,
  input  logic  rst_n_i,
  nmi_if.slave  core_nmi,
  nmi_if.slave  dma_nmi,
  nmi_if.master mstr_nmi
);

  logic s_lock_d;
  logic s_lock_q;
  logic s_owner_q;
  logic s_sel_dma;

  // free bus is granted in the same cycle, locked bus keeps its owner
  assign s_sel_dma = s_lock_q ? s_owner_q : dma_nmi.valid;

  always_comb begin
    s_lock_d = s_lock_q;
    if (!s_lock_q) begin
      s_lock_d = core_nmi.valid || dma_nmi.valid;
    end else if (mstr_nmi.ready) begin
      // owner transfer done, release on this edge
      s_lock_d = 1'b0;
    end
  end

  // owner follows the grant, which holds while locked
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      s_lock_q  <= 1'b0;
      s_owner_q <= 1'b0;
    end else begin
      s_lock_q  <= s_lock_d;
      s_owner_q <= s_sel_dma;
    end
  end

  // request mux toward the slice
  assign mstr_nmi.valid = s_sel_dma ? dma_nmi.valid : core_nmi.valid;
  assign mstr_nmi.addr  = s_sel_dma ? dma_nmi.addr  : core_nmi.addr;
  assign mstr_nmi.wdata = s_sel_dma ? dma_nmi.wdata : core_nmi.wdata;
  assign mstr_nmi.wstrb = s_sel_dma ? dma_nmi.wstrb : core_nmi.wstrb;

  // the losing master gets zero
  assign dma_nmi.ready  = s_sel_dma ? mstr_nmi.ready : 1'b0;
  assign dma_nmi.rdata  = s_sel_dma ? mstr_nmi.rdata : '0;
  assign core_nmi.ready = s_sel_dma ? 1'b0 : mstr_nmi.ready;
  assign core_nmi.rdata = s_sel_dma ? '0 : mstr_nmi.rdata;

endmodule

`default_nettype wire

/* hw/bus_decoder.sv */
/*
 * Address decoder on the output side of the bus.
 * Routes the sliced request to the native or APB target, or
 * drives the synchronous SRAM macro, and muxes the response
 * of whichever target completed back to the request side.
 */
`timescale 1ns/10ps
`default_nettype none

module bus_decoder
  import soc_bus_pkg::*;
  import soc_mmap_pkg::*;
#(
  parameter int unsigned RAM_AW = 15
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  nmi_if.slave              req_nmi,
  nmi_if.master             natv_nmi,
  nmi_if.master             apb_nmi,
  output logic [RAM_AW-1:0] ram_addr_o,
  output logic [DATA_W-1:0] ram_wdata_o,
  output strb_t             ram_wstrb_o,
  input  logic [DATA_W-1:0] ram_rdata_i
);

  region_e s_region;
  logic    s_ram_valid;
  logic    s_ram_ready_q;
  logic    s_ram_done;
  logic    s_natv_done;
  logic    s_apb_done;

  assign s_region = addr_region(req_nmi.addr);

  // native target
  assign natv_nmi.valid = req_nmi.valid && (s_region == NATV);
  assign natv_nmi.addr  = req_nmi.addr;
  assign natv_nmi.wdata = req_nmi.wdata;
  assign natv_nmi.wstrb = req_nmi.wstrb;

  // APB target
  assign apb_nmi.valid  = req_nmi.valid && (s_region == APB);
  assign apb_nmi.addr   = req_nmi.addr;
  assign apb_nmi.wdata  = req_nmi.wdata;
  assign apb_nmi.wstrb  = req_nmi.wstrb;

  // SRAM macro, word addressed
  assign s_ram_valid = req_nmi.valid && (s_region == SRAM);
  assign ram_addr_o  = req_nmi.addr[RAM_AW+1:2];
  assign ram_wdata_o = req_nmi.wdata;
  assign ram_wstrb_o = s_ram_valid ? req_nmi.wstrb : '0;

  // SRAM answers one cycle after select, then drops for the next request
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      s_ram_ready_q <= 1'b0;
    end else begin
      s_ram_ready_q <= s_ram_valid && !s_ram_ready_q;
    end
  end

  assign s_ram_done  = s_ram_valid && s_ram_ready_q;
  assign s_natv_done = natv_nmi.valid && natv_nmi.ready;
  assign s_apb_done  = apb_nmi.valid && apb_nmi.ready;

  // response mux
  assign req_nmi.ready = s_natv_done || s_apb_done || s_ram_done;

  always_comb begin
    req_nmi.rdata = '0;
    if (s_natv_done) begin
      req_nmi.rdata = natv_nmi.rdata;
    end else if (s_apb_done) begin
      req_nmi.rdata = apb_nmi.rdata;
    end else if (s_ram_done) begin
      req_nmi.rdata = ram_rdata_i;
    end
  end

endmodule

`default_nettype wire

/* hw/nmi_if.sv */
/*
 * Native memory interface, a valid/ready request channel.
 * The master holds valid and the request fields until ready;
 * the slave answers with a one cycle ready and rdata for reads.
 */
`timescale 1ns/10ps
`default_nettype none

interface nmi_if
  import soc_bus_pkg::*;
();

  logic              valid;
  logic [ADDR_W-1:0] addr;
  logic [DATA_W-1:0] wdata;
  strb_t             wstrb;
  logic              ready;
  logic [DATA_W-1:0] rdata;

  modport master(output valid, addr, wdata, wstrb, input ready, rdata);

  modport slave(input valid, addr, wdata, wstrb, output ready, rdata);

endinterface

`default_nettype wire

/* hw/nmi_regslice.sv */
/*
 * Single entry register slice on the request path.
 * Breaks the path from arbitration to address decode; the
 * response goes back upstream without a register.
 */
`timescale 1ns/10ps
`default_nettype none

module nmi_regslice
  import soc_bus_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_n_i,
  nmi_if.slave  slv_nmi,
  nmi_if.master mst_nmi
);

  logic              s_full_q;
  logic              s_load;
  logic [ADDR_W-1:0] s_addr_q;
  logic [DATA_W-1:0] s_wdata_q;
  strb_t             s_wstrb_q;

  // only an empty entry takes a request, so the held one is never taken twice
  assign s_load = !s_full_q && slv_nmi.valid;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      s_full_q <= 1'b0;
    end else if (s_load) begin
      s_full_q <= 1'b1;
    end else if (s_full_q && mst_nmi.ready) begin
      s_full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (s_load) begin
      s_addr_q  <= slv_nmi.addr;
      s_wdata_q <= slv_nmi.wdata;
      s_wstrb_q <= slv_nmi.wstrb;
    end
  end

  assign mst_nmi.valid = s_full_q;
  assign mst_nmi.addr  = s_addr_q;
  assign mst_nmi.wdata = s_wdata_q;
  assign mst_nmi.wstrb = s_wstrb_q;

  // response straight through
  assign slv_nmi.ready = s_full_q && mst_nmi.ready;
  assign slv_nmi.rdata = mst_nmi.rdata;

endmodule

`default_nettype wire

/* hw/soc_bus.sv */
/*
 * Top level of the bus interconnect.
 * CPU and DMA masters enter through the arbiter, pass the
 * register slice and leave through the address decoder to
 * the native, APB and SRAM targets.
 */
`timescale 1ns/10ps
`default_nettype none

module soc_bus
  import soc_bus_pkg::*;
#(
  parameter int unsigned RAM_AW = 15
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  // CPU core master
  input  logic              core_valid_i,
  input  logic [ADDR_W-1:0] core_addr_i,
  input  logic [DATA_W-1:0] core_wdata_i,
  input  strb_t             core_wstrb_i,
  output logic              core_ready_o,
  output logic [DATA_W-1:0] core_rdata_o,
  // DMA master
  input  logic              dma_valid_i,
  input  logic [ADDR_W-1:0] dma_addr_i,
  input  logic [DATA_W-1:0] dma_wdata_i,
  input  strb_t             dma_wstrb_i,
  output logic              dma_ready_o,
  output logic [DATA_W-1:0] dma_rdata_o,
  // native target
  output logic              natv_valid_o,
  output logic [ADDR_W-1:0] natv_addr_o,
  output logic [DATA_W-1:0] natv_wdata_o,
  output strb_t             natv_wstrb_o,
  input  logic              natv_ready_i,
  input  logic [DATA_W-1:0] natv_rdata_i,
  // APB target
  output logic              apb_valid_o,
  output logic [ADDR_W-1:0] apb_addr_o,
  output logic [DATA_W-1:0] apb_wdata_o,
  output strb_t             apb_wstrb_o,
  input  logic              apb_ready_i,
  input  logic [DATA_W-1:0] apb_rdata_i,
  // SRAM macro
  output logic [RAM_AW-1:0] ram_addr_o,
  output logic [DATA_W-1:0] ram_wdata_o,
  output strb_t             ram_wstrb_o,
  input  logic [DATA_W-1:0] ram_rdata_i
);

  nmi_if core_nmi ();
  nmi_if dma_nmi ();
  nmi_if arb_nmi ();
  nmi_if rgsl_nmi ();
  nmi_if natv_nmi ();
  nmi_if apb_nmi ();

  assign core_nmi.valid = core_valid_i;
  assign core_nmi.addr  = core_addr_i;
  assign core_nmi.wdata = core_wdata_i;
  assign core_nmi.wstrb = core_wstrb_i;
  assign core_ready_o   = core_nmi.ready;
  assign core_rdata_o   = core_nmi.rdata;

  assign dma_nmi.valid  = dma_valid_i;
  assign dma_nmi.addr   = dma_addr_i;
  assign dma_nmi.wdata  = dma_wdata_i;
  assign dma_nmi.wstrb  = dma_wstrb_i;
  assign dma_ready_o    = dma_nmi.ready;
  assign dma_rdata_o    = dma_nmi.rdata;

  assign natv_valid_o   = natv_nmi.valid;
  assign natv_addr_o    = natv_nmi.addr;
  assign natv_wdata_o   = natv_nmi.wdata;
  assign natv_wstrb_o   = natv_nmi.wstrb;
  assign natv_nmi.ready = natv_ready_i;
  assign natv_nmi.rdata = natv_rdata_i;

  assign apb_valid_o    = apb_nmi.valid;
  assign apb_addr_o     = apb_nmi.addr;
  assign apb_wdata_o    = apb_nmi.wdata;
  assign apb_wstrb_o    = apb_nmi.wstrb;
  assign apb_nmi.ready  = apb_ready_i;
  assign apb_nmi.rdata  = apb_rdata_i;

  bus_arbiter u_bus_arbiter (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .core_nmi (core_nmi),
    .dma_nmi  (dma_nmi),
    .mstr_nmi (arb_nmi)
  );

  nmi_regslice u_nmi_regslice (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .slv_nmi (arb_nmi),
    .mst_nmi (rgsl_nmi)
  );

  bus_decoder #(
    .RAM_AW (RAM_AW)
  ) u_bus_decoder (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_nmi     (rgsl_nmi),
    .natv_nmi    (natv_nmi),
    .apb_nmi     (apb_nmi),
    .ram_addr_o  (ram_addr_o),
    .ram_wdata_o (ram_wdata_o),
    .ram_wstrb_o (ram_wstrb_o),
    .ram_rdata_i (ram_rdata_i)
  );

endmodule

`default_nettype wire

/* hw/soc_bus_pkg.sv */
/*
 * Common widths and types of the native memory bus.
 * Imported by the bus interface and every block that
 * stores or routes a request.
 */
`default_nettype none

package soc_bus_pkg;

  // byte address and data widths
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;

  // one write enable per data byte
  localparam int unsigned STRB_W = DATA_W / 8;

  // all zero marks a read
  typedef logic [STRB_W-1:0] strb_t;

endpackage

`default_nettype wire

/* hw/soc_mmap_pkg.sv */
/*
 * System address map of the bus.
 * Regions are keyed on the top nibble or byte of the address.
 * addr_region() names the target that owns an address and is
 * shared by the decoder and the testbench.
 */
`default_nettype none

package soc_mmap_pkg;
  import soc_bus_pkg::*;

  // top nibble regions
  localparam logic [3:0] FLASH_START   = 4'h0;
  localparam logic [3:0] NATV_IP_START = 4'h1;
  localparam logic [3:0] APB_IP_START  = 4'h2;
  localparam logic [3:0] PSRAM_START   = 4'h8;
  localparam logic [3:0] SPISD_START0  = 4'h9;
  localparam logic [3:0] SPISD_START1  = 4'hA;
  localparam logic [3:0] SPISD_START2  = 4'hB;
  localparam logic [3:0] SPISD_START3  = 4'hC;

  // top byte regions, both bounds inclusive
  localparam logic [7:0] SRAM_START  = 8'h30;
  localparam logic [7:0] SRAM_END    = 8'h3F;
  localparam logic [7:0] SDRAM_START = 8'h40;
  localparam logic [7:0] SDRAM_END   = 8'h7F;

  typedef enum logic [1:0] {
    NATV = 2'd0,
    APB  = 2'd1,
    SRAM = 2'd2,
    NONE = 2'd3
  } region_e;

  function automatic region_e addr_region(input logic [ADDR_W-1:0] addr);
    logic [3:0] nib;
    logic [7:0] top;
    nib = addr[ADDR_W-1 -: 4];
    top = addr[ADDR_W-1 -: 8];
    if (top >= SRAM_START && top <= SRAM_END) begin
      return SRAM;
    end
    if (nib == APB_IP_START) begin
      return APB;
    end
    if (nib == FLASH_START || nib == NATV_IP_START || nib == PSRAM_START ||
        nib == SPISD_START0 || nib == SPISD_START1 || nib == SPISD_START2 ||
        nib == SPISD_START3 || (top >= SDRAM_START && top <= SDRAM_END)) begin
      return NATV;
    end
    return NONE;
  endfunction

endpackage

`default_nettype wire

/* sim/soc_bus_properties.sv */
/*
 * Protocol rules of the bus interconnect, bound into the top level.
 * Covers target selection, grant exclusivity, SRAM strobes and
 * idle outputs in reset.
 */
`timescale 1ns/10ps
`default_nettype none

module soc_bus_properties
  import soc_bus_pkg::*;
  import soc_mmap_pkg::*;
(
  input logic              clk_i,
  input logic              rst_n_i,
  input logic              natv_valid_i,
  input logic              apb_valid_i,
  input logic              core_ready_i,
  input logic              dma_ready_i,
  input strb_t             ram_wstrb_i,
  input logic              req_valid_i,
  input logic [ADDR_W-1:0] req_addr_i
);

  int unsigned fail_cnt = 0;
  logic        ram_sel;

  // routed request that targets the SRAM
  assign ram_sel = req_valid_i && (addr_region(req_addr_i) == SRAM);

  one_target: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0({natv_valid_i, apb_valid_i, ram_sel}))
    else begin
      fail_cnt++;
      $error("more than one target selected");
    end

  one_ready: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(core_ready_i && dma_ready_i))
    else begin
      fail_cnt++;
      $error("core and DMA ready together");
    end

  ram_strobe: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (ram_wstrb_i != '0) |-> ram_sel)
    else begin
      fail_cnt++;
      $error("SRAM strobe outside an SRAM access");
    end

  reset_idle: assert property (@(posedge clk_i)
    !rst_n_i |-> (!natv_valid_i && !apb_valid_i && !core_ready_i && !dma_ready_i &&
                  ram_wstrb_i == '0))
    else begin
      fail_cnt++;
      $error("control output active in reset");
    end

endmodule

bind soc_bus soc_bus_properties i_soc_bus_properties (
  .clk_i        (clk_i),
  .rst_n_i      (rst_n_i),
  .natv_valid_i (natv_valid_o),
  .apb_valid_i  (apb_valid_o),
  .core_ready_i (core_ready_o),
  .dma_ready_i  (dma_ready_o),
  .ram_wstrb_i  (ram_wstrb_o),
  .req_valid_i  (rgsl_nmi.valid),
  .req_addr_i   (rgsl_nmi.addr)
);

`default_nettype wire

/* sim/tb_soc_bus.sv */
/*
 * Testbench of the bus interconnect.
 * Drives the CPU and DMA masters, models the native, APB and SRAM
 * targets and checks routing, arbitration order and read data
 * against a reference memory. Protocol rules sit in the bound
 * property module.
 */
`timescale 1ns/10ps
`default_nettype none

module tb_soc_bus
  import soc_bus_pkg::*;
  import soc_mmap_pkg::*;
();

  localparam int unsigned RAM_AW      = 15;
  localparam int unsigned N_RAND      = 24;
  localparam int unsigned N_XFER      = 13 + 2 * N_RAND;
  localparam int unsigned WORST_CYC   = 24;
  localparam int unsigned WATCHDOG_NS = (N_XFER * WORST_CYC + 40) * 100;

  logic              clk_i;
  logic              rst_n_i;
  logic              core_valid_i;
  logic [ADDR_W-1:0] core_addr_i;
  logic [DATA_W-1:0] core_wdata_i;
  strb_t             core_wstrb_i;
  logic              core_ready_o;
  logic [DATA_W-1:0] core_rdata_o;
  logic              dma_valid_i;
  logic [ADDR_W-1:0] dma_addr_i;
  logic [DATA_W-1:0] dma_wdata_i;
  strb_t             dma_wstrb_i;
  logic              dma_ready_o;
  logic [DATA_W-1:0] dma_rdata_o;
  logic              natv_valid_o;
  logic [ADDR_W-1:0] natv_addr_o;
  logic [DATA_W-1:0] natv_wdata_o;
  strb_t             natv_wstrb_o;
  logic              natv_ready_i;
  logic [DATA_W-1:0] natv_rdata_i;
  logic              apb_valid_o;
  logic [ADDR_W-1:0] apb_addr_o;
  logic [DATA_W-1:0] apb_wdata_o;
  strb_t             apb_wstrb_o;
  logic              apb_ready_i;
  logic [DATA_W-1:0] apb_rdata_i;
  logic [RAM_AW-1:0] ram_addr_o;
  logic [DATA_W-1:0] ram_wdata_o;
  strb_t             ram_wstrb_o;
  logic [DATA_W-1:0] ram_rdata_i;

  logic [15:0] lfsr_q = 16'd51;
  bit [31:0]   ref_mem [128];
  bit [31:0]   tgt_mem [2][128];
  bit [31:0]   sram_mem [2**RAM_AW];
  logic [31:0] dir_addr [3] = '{32'h1000_0010, 32'h2000_0024, 32'h3000_0038};

  // word address the SRAM macro latched one cycle back
  logic [RAM_AW-1:0] ram_raddr;

  // last request seen by a target model
  region_e     obs_tgt;
  logic [31:0] obs_addr;
  logic [31:0] obs_wdata;
  strb_t       obs_wstrb;

  int          stall_cycles;
  int          natv_wait;
  int          apb_wait;
  int unsigned done_cnt;
  int unsigned seq_a;
  int unsigned seq_b;

  logic [31:0] r_addr [2][N_RAND];
  logic [31:0] r_wdata [2][N_RAND];
  strb_t       r_strb [2][N_RAND];
  int          r_gap [2][N_RAND];

  soc_bus #(
    .RAM_AW (RAM_AW)
  ) i_soc_bus (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .core_valid_i (core_valid_i),
    .core_addr_i  (core_addr_i),
    .core_wdata_i (core_wdata_i),
    .core_wstrb_i (core_wstrb_i),
    .core_ready_o (core_ready_o),
    .core_rdata_o (core_rdata_o),
    .dma_valid_i  (dma_valid_i),
    .dma_addr_i   (dma_addr_i),
    .dma_wdata_i  (dma_wdata_i),
    .dma_wstrb_i  (dma_wstrb_i),
    .dma_ready_o  (dma_ready_o),
    .dma_rdata_o  (dma_rdata_o),
    .natv_valid_o (natv_valid_o),
    .natv_addr_o  (natv_addr_o),
    .natv_wdata_o (natv_wdata_o),
    .natv_wstrb_o (natv_wstrb_o),
    .natv_ready_i (natv_ready_i),
    .natv_rdata_i (natv_rdata_i),
    .apb_valid_o  (apb_valid_o),
    .apb_addr_o   (apb_addr_o),
    .apb_wdata_o  (apb_wdata_o),
    .apb_wstrb_o  (apb_wstrb_o),
    .apb_ready_i  (apb_ready_i),
    .apb_rdata_i  (apb_rdata_i),
    .ram_addr_o   (ram_addr_o),
    .ram_wdata_o  (ram_wdata_o),
    .ram_wstrb_o  (ram_wstrb_o),
    .ram_rdata_i  (ram_rdata_i)
  );

  // galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
    end
    return v;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                              input logic [31:0] new_w, input strb_t strb);
    logic [31:0] res;
    res = old_w;
    for (int b = 0; b < STRB_W; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

  // region base and word offset, the only address bits the tests vary
  function automatic int unsigned mem_key(input logic [31:0] addr);
    return {addr[30:28], addr[5:2]};
  endfunction

  task automatic report_error(input string msg);
    $display("** Error at %0d ns: %s", $time, msg);
    $display("Result: FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  // one native or APB target, called on each falling edge
  task automatic serve_target(input region_e tgt, input logic valid, input logic [31:0] addr,
                              input logic [31:0] wdata, input strb_t wstrb,
                              inout logic ready, inout logic [31:0] rdata, inout int wait_cnt);
    int unsigned k;
    k = mem_key(addr);
    if (ready) begin
      ready = 1'b0;
    end else if (valid) begin
      if (wait_cnt < 0) begin
        wait_cnt = (stall_cycles > 0) ? stall_cycles : int'(rand_bits(2));
      end
      if (wait_cnt == 0) begin
        if (wstrb != '0) begin
          tgt_mem[tgt][k] = merge_bytes(tgt_mem[tgt][k], wdata, wstrb);
        end
        rdata     = tgt_mem[tgt][k];
        obs_tgt   = tgt;
        obs_addr  = addr;
        obs_wdata = wdata;
        obs_wstrb = wstrb;
        ready     = 1'b1;
        wait_cnt  = -1;
      end else begin
        wait_cnt--;
      end
    end
  endtask

  task automatic bus_access(input bit use_dma, input logic [31:0] addr,
                            input logic [31:0] wdata, input strb_t wstrb,
                            output int unsigned seq);
    logic        done;
    logic [31:0] rdata;
    logic [31:0] exp_addr;
    region_e     rgn;
    int unsigned k;
    rgn = addr_region(addr);
    k   = mem_key(addr);
    @(negedge clk_i);
    if (use_dma) begin
      dma_addr_i  = addr;
      dma_wdata_i = wdata;
      dma_wstrb_i = wstrb;
      dma_valid_i = 1'b1;
    end else begin
      core_addr_i  = addr;
      core_wdata_i = wdata;
      core_wstrb_i = wstrb;
      core_valid_i = 1'b1;
    end
    done = 1'b0;
    while (!done) begin
      @(posedge clk_i);
      done = use_dma ? dma_ready_o : core_ready_o;
    end
    rdata = use_dma ? dma_rdata_o : core_rdata_o;
    done_cnt++;
    seq = done_cnt;
    // an SRAM read leaves no trace at the macro pins
    if (rgn != SRAM || wstrb != '0) begin
      exp_addr = (rgn == SRAM) ? 32'(addr[RAM_AW+1:2]) : addr;
      assert (obs_tgt == rgn && obs_addr == exp_addr && obs_wstrb == wstrb &&
              (wstrb == '0 || obs_wdata == wdata))
        else report_error($sformatf("request to 0x%08h reached %s with addr 0x%08h",
                                    addr, obs_tgt.name(), obs_addr));
    end
    obs_tgt = NONE;
    if (wstrb == '0) begin
      assert (rdata == ref_mem[k])
        else report_error($sformatf("read 0x%08h returned 0x%08h, expected 0x%08h",
                                    addr, rdata, ref_mem[k]));
    end else begin
      ref_mem[k] = merge_bytes(ref_mem[k], wdata, wstrb);
    end
    @(negedge clk_i);
    if (use_dma) begin
      dma_valid_i = 1'b0;
    end else begin
      core_valid_i = 1'b0;
    end
  endtask

  task automatic run_traffic(input bit use_dma);
    int unsigned seq;
    for (int i = 0; i < N_RAND; i++) begin
      repeat (r_gap[use_dma][i]) @(negedge clk_i);
      bus_access(use_dma, r_addr[use_dma][i], r_wdata[use_dma][i], r_strb[use_dma][i], seq);
    end
  endtask

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // target models and SRAM macro
  initial begin
    natv_ready_i = 1'b0;
    natv_rdata_i = '0;
    apb_ready_i  = 1'b0;
    apb_rdata_i  = '0;
    ram_rdata_i  = '0;
    ram_raddr    = '0;
    natv_wait    = -1;
    apb_wait     = -1;
    obs_tgt      = NONE;
    forever begin
      @(negedge clk_i);
      if (ram_wstrb_o != '0) begin
        sram_mem[ram_addr_o] = merge_bytes(sram_mem[ram_addr_o], ram_wdata_o, ram_wstrb_o);
        obs_tgt   = SRAM;
        obs_addr  = 32'(ram_addr_o);
        obs_wdata = ram_wdata_o;
        obs_wstrb = ram_wstrb_o;
      end
      // synchronous read, data belongs to the previous cycle's address
      ram_rdata_i = sram_mem[ram_raddr];
      ram_raddr   = ram_addr_o;
      serve_target(NATV, natv_valid_o, natv_addr_o, natv_wdata_o, natv_wstrb_o,
                   natv_ready_i, natv_rdata_i, natv_wait);
      serve_target(APB, apb_valid_o, apb_addr_o, apb_wdata_o, apb_wstrb_o,
                   apb_ready_i, apb_rdata_i, apb_wait);
    end
  end

  always @(negedge clk_i) begin
    if (i_soc_bus.i_soc_bus_properties.fail_cnt != 0) begin
      report_error("a bus protocol assertion failed");
    end
  end

  initial begin
    #(WATCHDOG_NS);
    report_error("watchdog expired before all bus transfers completed");
  end

  initial begin
    rst_n_i      = 1'b0;
    core_valid_i = 1'b0;
    core_addr_i  = '0;
    core_wdata_i = '0;
    core_wstrb_i = '0;
    dma_valid_i  = 1'b0;
    dma_addr_i   = '0;
    dma_wdata_i  = '0;
    dma_wstrb_i  = '0;
    stall_cycles = 0;
    done_cnt     = 0;
    repeat (4) @(negedge clk_i);
    assert (!natv_valid_o && !apb_valid_o && !core_ready_o && !dma_ready_o &&
            ram_wstrb_o == '0)
      else report_error("control outputs not idle after reset");
    rst_n_i = 1'b1;

    // full write, partial write, read back per region
    for (int r = 0; r < 3; r++) begin
      bus_access(1'b0, dir_addr[r], 32'hA5A5_5A5A ^ dir_addr[r], 4'hF, seq_a);
      bus_access(1'b0, dir_addr[r], 32'h1122_3344, 4'b0101, seq_a);
      bus_access(1'b0, dir_addr[r], 32'h0, 4'h0, seq_a);
    end

    // simultaneous requests on a free bus
    fork
      bus_access(1'b1, 32'h4000_0008, 32'hDEAD_BEEF, 4'hF, seq_a);
      bus_access(1'b0, 32'h3000_0004, 32'hCAFE_F00D, 4'hF, seq_b);
    join
    assert (seq_a < seq_b) else report_error("core finished before DMA on a tie");

    // core waits behind a stalled DMA transfer
    stall_cycles = 6;
    fork
      bus_access(1'b1, 32'h1000_0004, 32'h0BAD_F00D, 4'hF, seq_a);
      begin
        @(negedge clk_i);
        bus_access(1'b0, 32'h2000_0008, 32'h0, 4'h0, seq_b);
      end
    join
    stall_cycles = 0;
    assert (seq_a < seq_b) else report_error("core got the bus while DMA was stalled");

    // random interleaved traffic, built before any target draws from the LFSR
    for (int m = 0; m < 2; m++) begin
      for (int i = 0; i < N_RAND; i++) begin
        r_addr[m][i]  = ((rand_bits(2) + 32'd1) << 28) | (rand_bits(4) << 2);
        r_wdata[m][i] = rand_bits(32);
        r_strb[m][i]  = rand_bits(1) ? strb_t'(rand_bits(4)) : strb_t'(0);
        r_gap[m][i]   = int'(rand_bits(2));
      end
    end
    fork
      run_traffic(1'b1);
      run_traffic(1'b0);
    join

    repeat (2) @(negedge clk_i);
    if (i_soc_bus.i_soc_bus_properties.fail_cnt == 0) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      report_error("a bus protocol assertion failed");
    end
  end

endmodule

`default_nettype wire
